/* Bender.yml */
package:
  name: mxu

sources:
  - source/mxu_pkg.sv
  - source/mxu_cfg_if.sv
  - source/mxu_config.sv
  - source/mxu_mac.sv
  - source/mxu_skew.sv
  - source/mxu_core.sv
  - source/mxu_out_stage.sv
  - source/mxu_top.sv
  - target: test
    files:
      - testbench/mxu_assert.sv
      - testbench/tb_mxu.sv

/* source/mxu_cfg_if.sv */
/*
 * config bus from the register block to the array and the output stage
 */

interface mxu_cfg_if;
   import mxu_pkg::*;

   data_t      weights [0:MXU_ROWS-1][0:MXU_COLS-1]; // stationary weights
   precision_t precision;
   logic       relu_en;
   shift_t     shift;                                // arithmetic right shift

   // register block side
   modport cfg (
      output weights, precision, relu_en, shift
   );

   // systolic grid only needs the weights and the multiplier mode
   modport array (
      input weights, precision
   );

   // post-processing in the output stage
   modport post (
      input relu_en, shift
   );

endinterface

/* source/mxu_config.sv */
/*
 * config register block: weight matrix and control register,
 * written through a plain write strobe
 */

module mxu_config (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cfg_we,
   input  mxu_pkg::cfg_addr_t  cfg_addr,
   input  mxu_pkg::data_t      cfg_wdata,
   mxu_cfg_if.cfg              cfg
);
   import mxu_pkg::*;

   data_t      weights_q [0:MXU_ROWS-1][0:MXU_COLS-1];
   precision_t precision_q;
   logic       relu_en_q;
   shift_t     shift_q;

   // ==============================
   // control register
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         precision_q <= '0;
         relu_en_q   <= 1'b0;
         shift_q     <= '0;
      end else if (cfg_we && (cfg_addr == CFG_ADDR_CTRL)) begin
         precision_q <= cfg_wdata[0];
         relu_en_q   <= cfg_wdata[1];
         shift_q     <= cfg_wdata[6:2];   // bit 7 is spare
      end
   end

   // ==============================
   // weight matrix
   // ==============================
   // each weight compares against its own address, so anything past
   // the last weight simply hits no register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MXU_ROWS; i++) begin
            for (int j = 0; j < MXU_COLS; j++) begin
               weights_q[i][j] <= '0;
            end
         end
      end else if (cfg_we) begin
         for (int i = 0; i < MXU_ROWS; i++) begin
            for (int j = 0; j < MXU_COLS; j++) begin
               if (cfg_addr == cfg_addr_t'(CFG_ADDR_W0 + i * MXU_COLS + j)) begin
                  weights_q[i][j] <= cfg_wdata;
               end
            end
         end
      end
   end

   // registers straight onto the bus, no extra stage
   assign cfg.weights   = weights_q;
   assign cfg.precision = precision_q;
   assign cfg.relu_en   = relu_en_q;
   assign cfg.shift     = shift_q;

endmodule

/* source/mxu_core.sv */
/*
 * weight-stationary systolic grid of mxu_mac cells,
 * data flows down the columns and partial sums flow right
 */

module mxu_core (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            enable,
   input  mxu_pkg::data_t  x_skew  [0:mxu_pkg::MXU_COLS-1],
   mxu_cfg_if.array        cfg,
   output mxu_pkg::acc_t   row_sum [0:mxu_pkg::MXU_ROWS-1]
);
   import mxu_pkg::*;

   // per-cell inputs and registered outputs
   data_t cell_data_in  [0:MXU_ROWS-1][0:MXU_COLS-1];
   acc_t  cell_sum_in   [0:MXU_ROWS-1][0:MXU_COLS-1];
   data_t cell_data_out [0:MXU_ROWS-1][0:MXU_COLS-1];
   acc_t  cell_sum_out  [0:MXU_ROWS-1][0:MXU_COLS-1];

   // ==============================
   // cell grid
   // ==============================
   for (genvar i = 0; i < MXU_ROWS; i++) begin : g_row
      for (genvar j = 0; j < MXU_COLS; j++) begin : g_col

         if (i == 0) begin : g_top
            assign cell_data_in[i][j] = x_skew[j];
         end else begin : g_below
            assign cell_data_in[i][j] = cell_data_out[i-1][j];
         end

         if (j == 0) begin : g_first
            assign cell_sum_in[i][j] = '0;   // row starts from zero
         end else begin : g_chain
            assign cell_sum_in[i][j] = cell_sum_out[i][j-1];
         end

         mxu_mac u_mac (
            .clk       (clk),
            .rst_n     (rst_n),
            .enable    (enable),
            .precision (cfg.precision),
            .weight    (cfg.weights[i][j]),
            .data_in   (cell_data_in[i][j]),
            .sum_in    (cell_sum_in[i][j]),
            .data_out  (cell_data_out[i][j]),
            .sum_out   (cell_sum_out[i][j])
         );
      end

      // finished dot product leaves the last column
      assign row_sum[i] = cell_sum_out[i][MXU_COLS-1];
   end

endmodule

/* source/mxu_mac.sv */
/*
 * one systolic cell: int8 or int4x2 multiplier, accumulate adder,
 * sum register to the right and data register to the row below
 */

module mxu_mac (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 enable,
   input  mxu_pkg::precision_t  precision,
   input  mxu_pkg::data_t       weight,
   input  mxu_pkg::data_t       data_in,
   input  mxu_pkg::acc_t        sum_in,
   output mxu_pkg::data_t       data_out,
   output mxu_pkg::acc_t        sum_out
);
   import mxu_pkg::*;

   logic signed [15:0] prod8;     // full int8 x int8
   logic signed [7:0]  prod_lo;   // low nibble pair
   logic signed [7:0]  prod_hi;   // high nibble pair
   logic signed [8:0]  prod4;     // sum of both nibble products
   acc_t               product;

   // ==============================
   // multiplier
   // ==============================
   always_comb begin
      prod8   = $signed(data_in) * $signed(weight);
      prod_lo = $signed(data_in[3:0]) * $signed(weight[3:0]);
      prod_hi = $signed(data_in[7:4]) * $signed(weight[7:4]);
      prod4   = prod_lo + prod_hi;

      // sign extend whichever mode is active
      if (precision == 1'b1) begin
         product = acc_t'(prod4);
      end else begin
         product = acc_t'(prod8);
      end
   end

   // ==============================
   // forwarding registers
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sum_out  <= '0;
         data_out <= '0;
      end else if (enable) begin
         sum_out  <= sum_in + product;  // partial sum moves right
         data_out <= data_in;           // element moves down
      end
   end

endmodule

/* source/mxu_out_stage.sv */
/*
 * row deskew, arithmetic shift, optional relu and out_valid alignment
 */

module mxu_out_stage (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           enable,
   input  logic           in_valid,
   input  mxu_pkg::acc_t  row_sum [0:mxu_pkg::MXU_ROWS-1],
   mxu_cfg_if.post        cfg,
   output mxu_pkg::acc_t  y       [0:mxu_pkg::MXU_ROWS-1],
   output logic           out_valid
);
   import mxu_pkg::*;

   logic [MXU_LATENCY-1:0] vld_q;   // in_valid travelling with the data

   function automatic acc_t post_proc(acc_t v, shift_t sh, logic relu);
      acc_t s;
      s = v >>> sh;                    // keeps the sign
      if (relu && s[ACC_W-1]) begin
         s = '0;
      end
      return s;
   endfunction

   // ==============================
   // deskew per row
   // ==============================
   for (genvar i = 0; i < MXU_ROWS; i++) begin : g_row
      localparam int DLY = MXU_ROWS - 1 - i;   // upper rows finish earlier

      if (DLY == 0) begin : g_direct
         // bottom row is already aligned
         assign y[i] = post_proc(row_sum[i], cfg.shift, cfg.relu_en);
      end else begin : g_pipe
         acc_t dly_q    [0:DLY-1];   // last entry is the output register
         acc_t stage_in [0:DLY-1];

         always_comb begin
            stage_in[0] = row_sum[i];
            for (int k = 1; k < DLY; k++) begin
               stage_in[k] = dly_q[k-1];
            end
         end

         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               for (int k = 0; k < DLY; k++) begin
                  dly_q[k] <= '0;
               end
            end else if (enable) begin
               for (int k = 0; k < DLY - 1; k++) begin
                  dly_q[k] <= stage_in[k];
               end
               dly_q[DLY-1] <= post_proc(stage_in[DLY-1], cfg.shift, cfg.relu_en);
            end
         end

         assign y[i] = dly_q[DLY-1];
      end
   end

   // ==============================
   // valid pipeline
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else if (enable) begin
         vld_q <= {vld_q[MXU_LATENCY-2:0], in_valid};
      end
   end

   assign out_valid = vld_q[MXU_LATENCY-1];

endmodule

/* source/mxu_pkg.sv */
/*
 * shared package of the matrix-vector unit: array sizes, data widths,
 * config address map and the common vector typedefs
 */

package mxu_pkg;

   // ==============================
   // array geometry and widths
   // ==============================
   localparam int MXU_ROWS = 3;   // output rows, one weight row each
   localparam int MXU_COLS = 3;   // input vector elements
   localparam int DATA_W   = 8;   // input element and weight width
   localparam int ACC_W    = 24;  // partial sums and results

   // skew + grid + deskew, in enabled edges
   localparam int MXU_LATENCY = MXU_ROWS + MXU_COLS - 1;

   // ==============================
   // shared vector types
   // ==============================
   typedef logic [DATA_W-1:0]        data_t;      // int8 or two int4 nibbles
   typedef logic signed [ACC_W-1:0]  acc_t;
   typedef logic [3:0]               cfg_addr_t;
   typedef logic [0:0]               precision_t; // 0 int8, 1 int4x2
   typedef logic [4:0]               shift_t;

   // ==============================
   // config address map
   // ==============================
   // ctrl register: bit 0 precision, bit 1 relu_en, bits 6:2 shift
   localparam cfg_addr_t CFG_ADDR_CTRL = 4'd0;

   // W[i][j] lives at CFG_ADDR_W0 + i*MXU_COLS + j
   localparam cfg_addr_t CFG_ADDR_W0   = 4'd1;

endpackage

/* source/mxu_skew.sv */
/*
 * input skew triangle, column j delayed by j enabled cycles
 */

module mxu_skew (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            enable,
   input  mxu_pkg::data_t  x_in  [0:mxu_pkg::MXU_COLS-1],
   output mxu_pkg::data_t  x_out [0:mxu_pkg::MXU_COLS-1]
);
   import mxu_pkg::*;

   for (genvar j = 0; j < MXU_COLS; j++) begin : g_col
      if (j == 0) begin : g_direct
         // first column meets its sum in cell (0,0) right away
         assign x_out[j] = x_in[j];
      end else begin : g_delay
         data_t dly_q [0:j-1];

         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               for (int k = 0; k < j; k++) begin
                  dly_q[k] <= '0;
               end
            end else if (enable) begin
               dly_q[0] <= x_in[j];
               for (int k = 1; k < j; k++) begin
                  dly_q[k] <= dly_q[k-1];
               end
            end
         end

         assign x_out[j] = dly_q[j-1];   // oldest stage
      end
   end

endmodule

/* source/mxu_top.sv */
/*
 * matrix-vector unit top level: config block, input skew,
 * systolic core and output stage behind plain ports
 */

module mxu_top (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          enable,
   input  logic                                          in_valid,
   input  logic [mxu_pkg::MXU_COLS*mxu_pkg::DATA_W-1:0]  x,
   input  logic                                          cfg_we,
   input  mxu_pkg::cfg_addr_t                            cfg_addr,
   input  mxu_pkg::data_t                                cfg_wdata,
   output logic [mxu_pkg::MXU_ROWS*mxu_pkg::ACC_W-1:0]   y,
   output logic                                          out_valid
);
   import mxu_pkg::*;

   data_t x_cols [0:MXU_COLS-1];   // column 0 from the low bits
   data_t x_skew [0:MXU_COLS-1];
   acc_t  row_sum [0:MXU_ROWS-1];
   acc_t  y_rows [0:MXU_ROWS-1];

   mxu_cfg_if cfg_bus ();

   // ==============================
   // port packing
   // ==============================
   for (genvar j = 0; j < MXU_COLS; j++) begin : g_unpack
      assign x_cols[j] = x[j*DATA_W +: DATA_W];
   end

   for (genvar i = 0; i < MXU_ROWS; i++) begin : g_pack
      assign y[i*ACC_W +: ACC_W] = y_rows[i];   // row 0 low
   end

   mxu_config u_config (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg_bus.cfg)
   );

   mxu_skew u_skew (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (enable),
      .x_in   (x_cols),
      .x_out  (x_skew)
   );

   mxu_core u_core (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .x_skew  (x_skew),
      .cfg     (cfg_bus.array),
      .row_sum (row_sum)
   );

   mxu_out_stage u_out_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .in_valid  (in_valid),
      .row_sum   (row_sum),
      .cfg       (cfg_bus.post),
      .y         (y_rows),
      .out_valid (out_valid)
   );

endmodule

/* sources.f */
source/mxu_pkg.sv
source/mxu_cfg_if.sv
source/mxu_config.sv
source/mxu_mac.sv
source/mxu_skew.sv
source/mxu_core.sv
source/mxu_out_stage.sv
source/mxu_top.sv
testbench/mxu_assert.sv
testbench/tb_mxu.sv

/* testbench/mxu_assert.sv */
/*
 * concurrent checks on the top-level ports, bound into mxu_top
 */

module mxu_assert (
   input logic                                         clk,
   input logic                                         rst_n,
   input logic                                         cfg_we,
   input mxu_pkg::cfg_addr_t                           cfg_addr,
   input logic [mxu_pkg::MXU_ROWS*mxu_pkg::ACC_W-1:0]  y,
   input logic                                         out_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int n_fail = 0;   // failed assertions so far

   // valid pipeline stays clear in reset
   a_rst_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
      else begin
         $error("out_valid high while rst_n is low");
         n_fail++;
      end

   a_y_known: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> !$isunknown(y))
      else begin
         $error("y has unknown bits while out_valid is high");
         n_fail++;
      end

   // a write needs a known address
   a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      cfg_we |-> !$isunknown(cfg_addr))
      else begin
         $error("cfg_addr unknown during a config write");
         n_fail++;
      end

endmodule

bind mxu_top mxu_assert i_assert (.*);

/* testbench/tb_mxu.sv */
/*
 * directed testbench of the matrix-vector unit: clock, reset,
 * reference model, result monitor and compare tasks
 */

module tb_mxu;
   timeunit 1ns;
   timeprecision 100ps;
   import mxu_pkg::*;

   localparam int X_W = MXU_COLS * DATA_W;
   localparam int Y_W = MXU_ROWS * ACC_W;
   localparam int W_W = MXU_ROWS * MXU_COLS * DATA_W;

   logic           clk = 1'b0;
   logic           rst_n;
   logic           enable;
   logic           in_valid;
   logic [X_W-1:0] x;
   logic           cfg_we;
   cfg_addr_t      cfg_addr;
   data_t          cfg_wdata;
   logic [Y_W-1:0] y;
   logic           out_valid;

   // reference model state that follows every config write
   data_t      w_m [0:MXU_ROWS-1][0:MXU_COLS-1];
   precision_t prec_m;
   logic       relu_m;
   shift_t     shift_m;

   logic [Y_W-1:0] exp_q [$];   // results still in flight
   logic [Y_W-1:0] exp_y;
   int             n_results = 0;
   logic           edge_en = 1'b0;
   string          cur_test = "init";
   int             seed = 32'h3e38;

   mxu_top i_dut (.*);

   always #2 clk = ~clk;

   always @(posedge clk) edge_en <= enable;   // enable seen by this edge

   // ==============================
   // reporting and compares
   // ==============================
   task automatic abort_run(input string line);
      $display("Test FAILED");
      $display("%s", line);
      $fatal(1);
   endtask

   task automatic check_acc(input string test, input int row, input acc_t exp, input acc_t act);
      if (act !== exp) begin
         abort_run($sformatf("FAIL %s row %0d expected %0d actual %0d", test, row, exp, act));
      end
   endtask

   task automatic check_bit(input string test, input string what, input logic exp,
                            input logic act);
      if (act !== exp) begin
         abort_run($sformatf("FAIL %s %s expected %b actual %b", test, what, exp, act));
      end
   endtask

   task automatic check_count(input string test, input int exp, input int act);
      if (act != exp) begin
         abort_run($sformatf("FAIL %s result count expected %0d actual %0d", test, exp, act));
      end
   endtask

   // a new result shows up after every enabled edge with out_valid high
   always @(negedge clk) begin
      if (rst_n && edge_en && out_valid) begin
         if (exp_q.size() == 0) begin
            abort_run($sformatf("%s: out_valid came with no vector in flight", cur_test));
         end
         exp_y = exp_q.pop_front();
         for (int i = 0; i < MXU_ROWS; i++) begin
            check_acc(cur_test, i, exp_y[i*ACC_W +: ACC_W], y[i*ACC_W +: ACC_W]);
         end
         n_results++;
      end
   end

   // port assertions bound into the DUT
   always @(negedge clk) begin
      if (i_dut.i_assert.n_fail != 0) begin
         abort_run($sformatf("%s: an assertion on the DUT ports failed", cur_test));
      end
   end

   // ==============================
   // reference model
   // ==============================
   function automatic int nib_val(input logic [3:0] n);
      return (n >= 4'd8) ? int'(n) - 16 : int'(n);
   endfunction

   function automatic int elem_prod(input data_t w, input data_t d);
      if (prec_m == 1'b1) begin
         return nib_val(w[3:0]) * nib_val(d[3:0]) + nib_val(w[7:4]) * nib_val(d[7:4]);
      end
      return int'($signed(w)) * int'($signed(d));
   endfunction

   function automatic logic [Y_W-1:0] model_y(input logic [X_W-1:0] xv);
      logic [Y_W-1:0] r;
      int             acc;
      for (int i = 0; i < MXU_ROWS; i++) begin
         acc = 0;
         for (int j = 0; j < MXU_COLS; j++) begin
            acc += elem_prod(w_m[i][j], xv[j*DATA_W +: DATA_W]);
         end
         acc = acc >>> shift_m;
         if (relu_m && acc < 0) begin
            acc = 0;
         end
         r[i*ACC_W +: ACC_W] = acc_t'(acc);
      end
      return r;
   endfunction

   function automatic logic [X_W-1:0] rand_vec();
      int r;
      r = $random(seed);
      return r[X_W-1:0];
   endfunction

   // ==============================
   // drivers
   // ==============================
   task automatic step();
      @(posedge clk);
      #0.5;
   endtask

   task automatic cfg_write(input cfg_addr_t addr, input data_t data);
      int idx;
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      step();
      cfg_we = 1'b0;
      idx    = int'(addr) - int'(CFG_ADDR_W0);
      if (addr == CFG_ADDR_CTRL) begin
         prec_m  = data[0];
         relu_m  = data[1];
         shift_m = data[6:2];
      end else if (idx >= 0 && idx < MXU_ROWS * MXU_COLS) begin
         w_m[idx / MXU_COLS][idx % MXU_COLS] = data;
      end
   endtask

   task automatic set_ctrl(input precision_t p, input logic relu, input shift_t sh);
      cfg_write(CFG_ADDR_CTRL, {1'b0, sh, relu, p});
   endtask

   // byte k of wv is W[k / MXU_COLS][k % MXU_COLS]
   task automatic load_weights(input logic [W_W-1:0] wv);
      for (int k = 0; k < MXU_ROWS * MXU_COLS; k++) begin
         cfg_write(cfg_addr_t'(int'(CFG_ADDR_W0) + k), wv[k*DATA_W +: DATA_W]);
      end
   endtask

   task automatic load_random_weights();
      logic [W_W-1:0] wv;
      for (int k = 0; k < MXU_ROWS * MXU_COLS; k++) begin
         wv[k*DATA_W +: DATA_W] = data_t'($random(seed));
      end
      load_weights(wv);
   endtask

   task automatic send_vec(input logic [X_W-1:0] xv);
      x        = xv;
      in_valid = 1'b1;
      exp_q.push_back(model_y(xv));
      step();
   endtask

   task automatic wait_results(input int target);
      int cycles;
      cycles = 0;
      while (n_results < target) begin
         step();
         cycles++;
         if (cycles > 4 * MXU_LATENCY + 20) begin
            abort_run($sformatf("%s: timed out waiting for out_valid", cur_test));
         end
      end
      repeat (MXU_LATENCY + 2) step();   // nothing extra may follow
      check_count(cur_test, target, n_results);
   endtask

   // ==============================
   // directed tests
   // ==============================
   task automatic test_reset();
      cur_test = "reset";
      enable   = 1'b1;
      repeat (6) begin
         step();
         check_bit(cur_test, "out_valid", 1'b0, out_valid);
         for (int i = 0; i < MXU_ROWS; i++) begin
            check_acc(cur_test, i, acc_t'(0), y[i*ACC_W +: ACC_W]);
         end
      end
   endtask

   task automatic test_latency();
      int base;
      cur_test = "latency";
      base     = n_results;
      load_weights({8'd7, 8'hfd, 8'd2, 8'd1, 8'd0, 8'h80, 8'd5, 8'd4, 8'hf7});
      set_ctrl(1'b0, 1'b0, 5'd0);
      cfg_write(4'hf, 8'h55);   // past the last weight
      send_vec({8'd100, 8'hce, 8'h7f});
      in_valid = 1'b0;
      check_bit(cur_test, "out_valid", 1'b0, out_valid);
      for (int n = 1; n < MXU_LATENCY; n++) begin
         step();
         check_bit(cur_test, "out_valid", logic'(n == MXU_LATENCY - 1), out_valid);
      end
      wait_results(base + 1);
   endtask

   task automatic test_random(input string name, input precision_t p, input int count);
      int base;
      cur_test = name;
      base     = n_results;
      load_random_weights();
      set_ctrl(p, 1'b0, 5'd0);
      repeat (count) send_vec(rand_vec());   // back to back
      in_valid = 1'b0;
      wait_results(base + count);
   endtask

   task automatic test_post();
      int base;
      cur_test = "post";
      base     = n_results;
      // row 0 negative, row 1 positive, row 2 mixed
      load_weights({8'd9, 8'hf0, 8'd3, 8'd2, 8'd6, 8'd4, 8'hf9, 8'hfb, 8'hfd});
      set_ctrl(1'b0, 1'b1, 5'd2);
      send_vec({8'd30, 8'd20, 8'd10});
      send_vec({8'hf9, 8'hfa, 8'hfb});
      repeat (4) send_vec(rand_vec());
      in_valid = 1'b0;
      wait_results(base + 6);
   endtask

   task automatic test_stall();
      int             base;
      int             drop_count;
      logic [Y_W-1:0] held_y;
      logic           held_v;
      cur_test = "stall";
      base     = n_results;
      load_random_weights();
      set_ctrl(1'b0, 1'b0, 5'd0);
      repeat (6) send_vec(rand_vec());
      enable     = 1'b0;
      held_y     = y;
      held_v     = out_valid;
      drop_count = n_results;
      repeat (5) begin
         x = rand_vec();   // must not be sampled
         step();
         check_bit(cur_test, "held out_valid", held_v, out_valid);
         for (int i = 0; i < MXU_ROWS; i++) begin
            check_acc(cur_test, i, held_y[i*ACC_W +: ACC_W], y[i*ACC_W +: ACC_W]);
         end
      end
      // only the result of the last enabled edge is counted
      check_count(cur_test, drop_count + int'(held_v), n_results);
      enable = 1'b1;
      repeat (4) send_vec(rand_vec());
      in_valid = 1'b0;
      wait_results(base + 10);
   endtask

   // ==============================
   // main sequence
   // ==============================
   initial begin
      rst_n     = 1'b0;
      enable    = 1'b0;
      in_valid  = 1'b0;
      x         = '0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      prec_m    = '0;
      relu_m    = 1'b0;
      shift_m   = '0;
      for (int i = 0; i < MXU_ROWS; i++) begin
         for (int j = 0; j < MXU_COLS; j++) begin
            w_m[i][j] = '0;
         end
      end
      repeat (3) @(posedge clk);
      #0.5;
      rst_n = 1'b1;

      test_reset();
      test_latency();
      test_random("stream", 1'b0, 10);
      test_random("int4x2", 1'b1, 8);
      test_post();
      test_stall();

      if (exp_q.size() != 0) begin
         abort_run($sformatf("%0d results never arrived", exp_q.size()));
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule
